// File: hw/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define XLEN 64
`define NUM_REGS 32
`define PC_INIT 64'h0

// major opcodes of the supported subset
`define OP_OP 7'b0110011
`define OP_OP_IMM 7'b0010011
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011
`define OP_BRANCH 7'b1100011

`endif

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

	typedef enum logic [0:0] {
		BUS_READ = 1'b0,
		BUS_WRITE = 1'b1
	} bus_op_t;

	// only doubleword accesses are issued by the core
	typedef enum logic [1:0] {
		SIZE_B = 2'd0,
		SIZE_H = 2'd1,
		SIZE_W = 2'd2,
		SIZE_D = 2'd3
	} bus_size_t;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none
`include "core_config.svh"

package core_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset bits are scattered over the word
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [`XLEN-1:0] rs1_val;
		logic [`XLEN-1:0] rs2_val;
		logic [`XLEN-1:0] imm;
		alu_op_t alu_op;
		logic use_imm;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic writes_rd;
	} decoded_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [4:0] rd;
		logic [`XLEN-1:0] result;
		logic [`XLEN-1:0] store_data;
		logic is_load;
		logic is_store;
		logic writes_rd;
	} exec_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [4:0] rd;
		logic [`XLEN-1:0] value;
		logic writes_rd;
	} wb_t;

endpackage

`default_nettype wire

// File: hw/stage_intf.sv
`default_nettype none
`include "core_config.svh"

interface regfile_intf;
	logic [4:0] ra1;
	logic [4:0] ra2;
	logic [`XLEN-1:0] rd1;
	logic [`XLEN-1:0] rd2;
	logic we;
	logic [4:0] wa;
	logic [`XLEN-1:0] wd;

	modport regfile (input ra1, ra2, we, wa, wd, output rd1, rd2);
	modport decode (output ra1, ra2, input rd1, rd2);
	modport writeback (output we, wa, wd);
endinterface

interface hazard_intf;
	import core_pkg::*;

	logic [4:0] rs1_d;
	logic [4:0] rs2_d;
	logic [4:0] rs1_e;
	logic [4:0] rs2_e;
	logic [4:0] rd_e;
	logic is_load_e;
	logic branch_taken;
	logic [`XLEN-1:0] branch_target;
	logic [4:0] rd_m;
	logic writes_m;
	logic is_load_m;
	logic [4:0] rd_w;
	logic writes_w;
	logic mem_wait;
	logic stall_f;
	logic stall_d;
	logic stall_e;
	logic flush_d;
	logic flush_e;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;

	modport hazard (
		input rs1_d, rs2_d, rs1_e, rs2_e, rd_e, is_load_e, branch_taken,
		input rd_m, writes_m, is_load_m, rd_w, writes_w, mem_wait,
		output stall_f, stall_d, stall_e, flush_d, flush_e, fwd_a, fwd_b
	);
	modport decode (output rs1_d, rs2_d, input stall_d, stall_e, flush_d, flush_e);
	modport execute (
		output rs1_e, rs2_e, rd_e, is_load_e, branch_taken, branch_target,
		input fwd_a, fwd_b, mem_wait
	);
	modport core (
		output rd_m, writes_m, is_load_m, rd_w, writes_w, mem_wait,
		input stall_f, branch_taken, branch_target
	);
endinterface

`default_nettype wire

// File: hw/regfile.sv
`default_nettype none
`include "core_config.svh"

module regfile (
	input logic clk,
	input logic reset,
	regfile_intf.regfile self
);
	// x0 has no storage
	logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (self.we && self.wa != 5'd0) begin
			regs[self.wa] <= self.wd;
		end
	end

	// write-through so decode sees the value retiring this cycle
	always_comb begin
		if (self.ra1 == 5'd0)
			self.rd1 = '0;
		else if (self.we && self.wa == self.ra1)
			self.rd1 = self.wd;
		else
			self.rd1 = regs[self.ra1];
	end

	always_comb begin
		if (self.ra2 == 5'd0)
			self.rd2 = '0;
		else if (self.we && self.wa == self.ra2)
			self.rd2 = self.wd;
		else
			self.rd2 = regs[self.ra2];
	end
endmodule

`default_nettype wire

// File: hw/decode.sv
`default_nettype none
`include "core_config.svh"

module decode (
	input logic clk,
	input logic reset,
	input logic [`XLEN-1:0] pc,
	input core_pkg::instr_t instr,
	regfile_intf.decode regfile,
	hazard_intf.decode hazard,
	output core_pkg::decoded_t out_e
);
	import core_pkg::*;

	logic [`XLEN-1:0] pc_d;
	instr_t instr_d;
	decoded_t ctrl;
	decoded_t dec;

	// an all-zero word decodes to a bubble
	always_ff @(posedge clk) begin
		if (reset)
			instr_d <= '0;
		else if (hazard.flush_d)
			instr_d <= '0;
		else if (!hazard.stall_d)
			instr_d <= instr;
	end

	always_ff @(posedge clk) begin
		if (!hazard.stall_d)
			pc_d <= pc;
	end

	always_comb begin
		ctrl = '0;
		ctrl.pc = pc_d;
		ctrl.alu_op = ALU_ADD;
		case (instr_d.r_fmt.opcode)
			`OP_OP: begin
				ctrl.rs1 = instr_d.r_fmt.rs1;
				ctrl.rs2 = instr_d.r_fmt.rs2;
				ctrl.rd = instr_d.r_fmt.rd;
				ctrl.writes_rd = 1'b1;
				case (instr_d.r_fmt.funct3)
					3'b000: ctrl.alu_op = instr_d.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
					3'b100: ctrl.alu_op = ALU_XOR;
					3'b110: ctrl.alu_op = ALU_OR;
					3'b111: ctrl.alu_op = ALU_AND;
					default: ctrl.writes_rd = 1'b0;
				endcase
			end
			`OP_OP_IMM: begin
				ctrl.rs1 = instr_d.i_fmt.rs1;
				ctrl.rd = instr_d.i_fmt.rd;
				ctrl.imm = {{(`XLEN-12){instr_d.i_fmt.imm[11]}}, instr_d.i_fmt.imm};
				ctrl.use_imm = 1'b1;
				// addi only
				ctrl.writes_rd = (instr_d.i_fmt.funct3 == 3'b000);
			end
			`OP_LOAD: begin
				ctrl.rs1 = instr_d.i_fmt.rs1;
				ctrl.rd = instr_d.i_fmt.rd;
				ctrl.imm = {{(`XLEN-12){instr_d.i_fmt.imm[11]}}, instr_d.i_fmt.imm};
				ctrl.use_imm = 1'b1;
				ctrl.is_load = (instr_d.i_fmt.funct3 == 3'b011);
				ctrl.writes_rd = ctrl.is_load;
			end
			`OP_STORE: begin
				ctrl.rs1 = instr_d.s_fmt.rs1;
				ctrl.rs2 = instr_d.s_fmt.rs2;
				ctrl.imm = {{(`XLEN-12){instr_d.s_fmt.imm_hi[6]}},
					instr_d.s_fmt.imm_hi, instr_d.s_fmt.imm_lo};
				ctrl.use_imm = 1'b1;
				ctrl.is_store = (instr_d.s_fmt.funct3 == 3'b011);
			end
			`OP_BRANCH: begin
				ctrl.rs1 = instr_d.b_fmt.rs1;
				ctrl.rs2 = instr_d.b_fmt.rs2;
				ctrl.imm = {{(`XLEN-13){instr_d.b_fmt.imm12}}, instr_d.b_fmt.imm12,
					instr_d.b_fmt.imm11, instr_d.b_fmt.imm10_5, instr_d.b_fmt.imm4_1, 1'b0};
				ctrl.is_branch = (instr_d.b_fmt.funct3 == 3'b000);
			end
			default: ;
		endcase
		// writes to x0 are dropped here, so they never retire or forward
		if (ctrl.rd == 5'd0)
			ctrl.writes_rd = 1'b0;
	end

	assign regfile.ra1 = ctrl.rs1;
	assign regfile.ra2 = ctrl.rs2;
	assign hazard.rs1_d = ctrl.rs1;
	assign hazard.rs2_d = ctrl.rs2;

	always_comb begin
		dec = ctrl;
		dec.rs1_val = regfile.rd1;
		dec.rs2_val = regfile.rd2;
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_e <= '0;
		else if (!hazard.stall_e) begin
			if (hazard.flush_e)
				out_e <= '0;
			else
				out_e <= dec;
		end
	end
endmodule

`default_nettype wire

// File: hw/execute.sv
`default_nettype none
`include "core_config.svh"

module execute (
	input logic clk,
	input logic reset,
	input core_pkg::decoded_t in_e,
	input logic [`XLEN-1:0] m_value,
	input logic [`XLEN-1:0] w_value,
	hazard_intf.execute hazard,
	output core_pkg::exec_t out_m
);
	import core_pkg::*;

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_b;
	logic [`XLEN-1:0] result;
	exec_t next_m;

	always_comb begin
		case (hazard.fwd_a)
			FWD_MEM: op_a = m_value;
			FWD_WB: op_a = w_value;
			default: op_a = in_e.rs1_val;
		endcase
		case (hazard.fwd_b)
			FWD_MEM: op_b = m_value;
			FWD_WB: op_b = w_value;
			default: op_b = in_e.rs2_val;
		endcase
	end

	// loads and stores use the adder for their address
	assign alu_b = in_e.use_imm ? in_e.imm : op_b;

	always_comb begin
		case (in_e.alu_op)
			ALU_SUB: result = op_a - alu_b;
			ALU_AND: result = op_a & alu_b;
			ALU_OR: result = op_a | alu_b;
			ALU_XOR: result = op_a ^ alu_b;
			default: result = op_a + alu_b;
		endcase
	end

	assign hazard.branch_taken = in_e.is_branch && (op_a == op_b);
	assign hazard.branch_target = in_e.pc + in_e.imm;
	assign hazard.rs1_e = in_e.rs1;
	assign hazard.rs2_e = in_e.rs2;
	assign hazard.rd_e = in_e.rd;
	assign hazard.is_load_e = in_e.is_load;

	always_comb begin
		next_m.pc = in_e.pc;
		next_m.rd = in_e.rd;
		next_m.result = result;
		next_m.store_data = op_b;
		next_m.is_load = in_e.is_load;
		next_m.is_store = in_e.is_store;
		next_m.writes_rd = in_e.writes_rd;
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_m <= '0;
		else if (!hazard.mem_wait)
			out_m <= next_m;
	end
endmodule

`default_nettype wire

// File: hw/hazard.sv
`default_nettype none

module hazard (
	hazard_intf.hazard self
);
	import core_pkg::*;

	logic m_ok;
	logic load_use;

	function automatic fwd_sel_t fwd_for(
		input logic [4:0] rs,
		input logic [4:0] rd_m,
		input logic m_hit,
		input logic [4:0] rd_w,
		input logic w_hit
	);
		if (rs == 5'd0)
			return FWD_REG;
		// the younger result wins
		if (m_hit && rd_m == rs)
			return FWD_MEM;
		if (w_hit && rd_w == rs)
			return FWD_WB;
		return FWD_REG;
	endfunction

	// load data only exists once dack arrives
	assign m_ok = self.writes_m && (!self.is_load_m || !self.mem_wait);

	always_comb begin
		self.fwd_a = fwd_for(self.rs1_e, self.rd_m, m_ok, self.rd_w, self.writes_w);
		self.fwd_b = fwd_for(self.rs2_e, self.rd_m, m_ok, self.rd_w, self.writes_w);
	end

	assign load_use = self.is_load_e && self.rd_e != 5'd0 &&
		(self.rd_e == self.rs1_d || self.rd_e == self.rs2_d);

	assign self.stall_f = load_use || self.mem_wait;
	assign self.stall_d = load_use || self.mem_wait;
	assign self.stall_e = self.mem_wait;
	// a branch held by the memory stage flushes once it moves
	assign self.flush_d = self.branch_taken && !self.mem_wait;
	assign self.flush_e = (self.branch_taken || load_use) && !self.mem_wait;
endmodule

`default_nettype wire

// File: hw/core.sv
`default_nettype none
`include "core_config.svh"

module core (
	input logic clk,
	input logic reset,
	output logic [`XLEN-1:0] imem_addr,
	input logic [31:0] imem_data,
	output logic dreq,
	input logic dack,
	output bus_pkg::bus_op_t dop,
	output bus_pkg::bus_size_t dsize,
	output logic [`XLEN-1:0] daddr,
	output logic [`XLEN-1:0] dwdata,
	input logic [`XLEN-1:0] drdata,
	output logic retire_valid,
	output logic [`XLEN-1:0] retire_pc,
	output logic [4:0] retire_rd,
	output logic [`XLEN-1:0] retire_data
);
	import core_pkg::*;
	import bus_pkg::*;

	logic [`XLEN-1:0] pc;
	decoded_t e_reg;
	exec_t m_reg;
	wb_t w_reg;
	wb_t next_w;
	logic w_fwd;
	logic m_access;
	logic [`XLEN-1:0] m_value;

	regfile_intf rf ();
	hazard_intf hz ();

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `PC_INIT;
		else if (!hz.stall_f)
			pc <= hz.branch_taken ? hz.branch_target : pc + 64'd4;
	end

	assign imem_addr = pc;

	regfile regfile_inst (
		.clk,
		.reset,
		.self(rf.regfile)
	);

	decode decode_inst (
		.clk,
		.reset,
		.pc(pc),
		.instr(imem_data),
		.regfile(rf.decode),
		.hazard(hz.decode),
		.out_e(e_reg)
	);

	execute execute_inst (
		.clk,
		.reset,
		.in_e(e_reg),
		.m_value(m_value),
		.w_value(w_reg.value),
		.hazard(hz.execute),
		.out_m(m_reg)
	);

	hazard hazard_inst (
		.self(hz.hazard)
	);

	// one four-phase data bus transfer per load or store in the memory stage
	assign m_access = m_reg.is_load || m_reg.is_store;
	assign hz.mem_wait = m_access && !(dreq && dack);

	always_ff @(posedge clk) begin
		if (reset)
			dreq <= 1'b0;
		else if (dreq) begin
			if (dack)
				dreq <= 1'b0;
		end else if (m_access && !dack) begin
			// previous transfer must see dack low first
			dreq <= 1'b1;
		end
	end

	assign dop = m_reg.is_store ? BUS_WRITE : BUS_READ;
	assign dsize = SIZE_D;
	assign daddr = m_reg.result;
	assign dwdata = m_reg.store_data;

	// load data is only meaningful in the cycle dack is seen
	assign m_value = m_reg.is_load ? drdata : m_reg.result;

	assign hz.rd_m = m_reg.rd;
	assign hz.writes_m = m_reg.writes_rd;
	assign hz.is_load_m = m_reg.is_load;
	assign hz.rd_w = w_reg.rd;
	assign hz.writes_w = w_fwd;

	always_comb begin
		next_w.pc = m_reg.pc;
		next_w.rd = m_reg.rd;
		next_w.value = m_value;
		next_w.writes_rd = m_reg.writes_rd;
	end

	always_ff @(posedge clk) begin
		if (reset)
			w_reg.writes_rd <= 1'b0;
		else if (hz.mem_wait)
			w_reg.writes_rd <= 1'b0;
		else
			w_reg <= next_w;
	end

	// execute keeps forwarding the held writeback value while memory waits
	always_ff @(posedge clk) begin
		if (reset)
			w_fwd <= 1'b0;
		else if (!hz.mem_wait)
			w_fwd <= next_w.writes_rd;
	end

	assign rf.we = w_reg.writes_rd;
	assign rf.wa = w_reg.rd;
	assign rf.wd = w_reg.value;

	assign retire_valid = w_reg.writes_rd;
	assign retire_pc = w_reg.pc;
	assign retire_rd = w_reg.rd;
	assign retire_data = w_reg.value;
endmodule

`default_nettype wire

// File: test/core_properties.sv
`default_nettype none
`include "core_config.svh"

module core_properties (
	input logic clk,
	input logic reset,
	input logic dreq,
	input logic dack,
	input bus_pkg::bus_op_t dop,
	input logic [`XLEN-1:0] daddr,
	input logic [`XLEN-1:0] dwdata,
	input logic retire_valid
);
	int errors = 0;

	// request fields hold until the memory answers
	request_stable: assert property (@(posedge clk) disable iff (reset)
		dreq && !dack |=> $stable(daddr) && $stable(dop) && $stable(dwdata))
	else begin
		errors++;
		$error("data bus request changed before dack");
	end

	// four-phase return to zero before the next request
	no_rise_on_ack: assert property (@(posedge clk) disable iff (reset)
		!dreq && dack |=> !dreq)
	else begin
		errors++;
		$error("dreq rose while dack was still high");
	end

	quiet_after_reset: assert property (@(posedge clk) reset |=> !dreq && !retire_valid)
	else begin
		errors++;
		$error("dreq or retire_valid high right after reset");
	end
endmodule

bind core core_properties props_inst (
	.clk(clk),
	.reset(reset),
	.dreq(dreq),
	.dack(dack),
	.dop(dop),
	.daddr(daddr),
	.dwdata(dwdata),
	.retire_valid(retire_valid)
);

`default_nettype wire

// File: test/core_tb.sv
`default_nettype none
`include "core_config.svh"

module core_clock (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end
endmodule

module core_tb;
	import bus_pkg::*;

	logic clk;
	logic reset;
	logic [`XLEN-1:0] imem_addr;
	logic [31:0] imem_data;
	logic dreq;
	logic dack;
	bus_op_t dop;
	bus_size_t dsize;
	logic [`XLEN-1:0] daddr;
	logic [`XLEN-1:0] dwdata;
	logic [`XLEN-1:0] drdata;
	logic retire_valid;
	logic [`XLEN-1:0] retire_pc;
	logic [4:0] retire_rd;
	logic [`XLEN-1:0] retire_data;

	// counts at 0, program at 'h10, memory at 'h40, retires at 'h60, stores at 'hc0
	logic [`XLEN-1:0] vec [0:255];
	logic [31:0] rom [0:63];
	logic [`XLEN-1:0] dmem [logic [`XLEN-1:0]];
	int n_prog;
	int n_mem;
	int n_retire;
	int n_store;
	int retire_idx;
	int store_idx;
	int last_idx;
	int delay_left;
	int cycles;
	integer seed = 32'h1de6_a636;

	core_clock clock_inst (
		.clk(clk),
		.reset(reset)
	);

	core core_inst (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dreq(dreq),
		.dack(dack),
		.dop(dop),
		.dsize(dsize),
		.daddr(daddr),
		.dwdata(dwdata),
		.drdata(drdata),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	// past the end of the program the core fetches all-zero words
	assign imem_data = (imem_addr[`XLEN-1:8] == '0) ? rom[imem_addr[7:2]] : 32'h0;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_retire(
		input logic [`XLEN-1:0] pc,
		input logic [4:0] rd,
		input logic [`XLEN-1:0] data
	);
		logic [`XLEN-1:0] exp_pc;
		logic [4:0] exp_rd;
		logic [`XLEN-1:0] exp_data;

		exp_pc = vec['h60 + 3 * retire_idx];
		exp_rd = vec['h61 + 3 * retire_idx][4:0];
		exp_data = vec['h62 + 3 * retire_idx];
		if (pc !== exp_pc)
			abort_run($sformatf("[FAIL] retire_pc: got %h expected %h", pc, exp_pc));
		if (rd !== exp_rd)
			abort_run($sformatf("[FAIL] retire_rd: got %h expected %h", rd, exp_rd));
		if (data !== exp_data)
			abort_run($sformatf("[FAIL] retire_data: got %h expected %h", data, exp_data));
	endtask

	task automatic check_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
		logic [`XLEN-1:0] exp_addr;
		logic [`XLEN-1:0] exp_data;

		if (store_idx >= n_store)
			abort_run("a store reached memory that was not expected");
		exp_addr = vec['hc0 + 2 * store_idx];
		exp_data = vec['hc1 + 2 * store_idx];
		if (addr !== exp_addr)
			abort_run($sformatf("[FAIL] daddr: got %h expected %h", addr, exp_addr));
		if (data !== exp_data)
			abort_run($sformatf("[FAIL] dwdata: got %h expected %h", data, exp_data));
	endtask

	// memory model that answers each request after 0 to 4 extra cycles
	always @(posedge clk) begin
		if (reset) begin
			dack <= 1'b0;
			delay_left = -1;
		end else if (dreq && !dack) begin
			if (retire_idx == 0 && !retire_valid)
				abort_run("bus request seen before the first instruction retired");
			if (delay_left < 0)
				delay_left = $unsigned($random(seed)) % 5;
			if (delay_left == 0) begin
				if (dsize !== SIZE_D)
					abort_run($sformatf("[FAIL] dsize: got %h expected %h", dsize, SIZE_D));
				if (dop == BUS_WRITE) begin
					check_store(daddr, dwdata);
					store_idx++;
					dmem[daddr] = dwdata;
				end else begin
					if (!dmem.exists(daddr))
						abort_run("load from an address that holds no data");
					drdata <= dmem[daddr];
				end
				dack <= 1'b1;
				delay_left = -1;
			end else begin
				delay_left = delay_left - 1;
			end
		end else if (!dreq && dack) begin
			dack <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (core_inst.props_inst.errors != 0)
			abort_run("a bus or reset assertion failed");
		if (!reset && retire_valid === 1'b1) begin
			if (retire_idx >= n_retire)
				abort_run("an instruction retired after the last expected record");
			check_retire(retire_pc, retire_rd, retire_data);
			retire_idx++;
		end
	end

	initial begin
		dack = 1'b0;
		drdata = '0;
		retire_idx = 0;
		store_idx = 0;
		delay_left = -1;
		$readmemh("test/core_vectors.txt", vec);
		n_prog = vec[0][31:0];
		n_mem = vec[1][31:0];
		n_retire = vec[2][31:0];
		n_store = vec[3][31:0];
		if (n_prog == 0 || n_retire == 0)
			abort_run("vector file is missing or holds no program");
		for (int i = 0; i < 64; i++)
			rom[i] = (i < n_prog) ? vec['h10 + i][31:0] : 32'h0;
		for (int i = 0; i < n_mem; i++)
			dmem[vec['h40 + 2 * i]] = vec['h41 + 2 * i];

		cycles = 0;
		while (reset !== 1'b0) begin
			@(negedge clk);
			cycles++;
			if (cycles > 20)
				abort_run("reset was not released within 20 cycles");
		end

		while (retire_idx < n_retire) begin
			last_idx = retire_idx;
			cycles = 0;
			while (retire_idx == last_idx) begin
				@(negedge clk);
				cycles++;
				if (cycles > 200)
					abort_run("no retire within 200 cycles");
			end
		end

		// drain so that a late retire or store is still caught
		repeat (20) @(negedge clk);
		if (store_idx != n_store) begin
			abort_run($sformatf("only %0d of %0d stores reached memory", store_idx, n_store));
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end
endmodule

`default_nettype wire

// File: core.f
+incdir+hw
hw/bus_pkg.sv
hw/core_pkg.sv
hw/stage_intf.sv
hw/regfile.sv
hw/decode.sv
hw/execute.sv
hw/hazard.sv
hw/core.sv
test/core_properties.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: core

sources:
  - include_dirs:
      - hw
    files:
      - hw/bus_pkg.sv
      - hw/core_pkg.sv
      - hw/stage_intf.sv
      - hw/regfile.sv
      - hw/decode.sv
      - hw/execute.sv
      - hw/hazard.sv
      - hw/core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/core_properties.sv
      - test/core_tb.sv

// File: test/core_vectors.txt
// @00 counts: program words, memory pairs, retire records, store records
// @10 program, @40 memory (address data), @60 retires (pc rd data), @c0 stores (address data)
@00 15 2 e 2
@10
00500093 ffd00113 002081b3 40118233 002242b3 0030e333 002373b3 00108033
10000413 00043483 00148533 00a43823 00843583 00208463 00100613 00028663
06300693 04d00713 00c587b3 00f43c23 00100833
@40
0000000000000100 0123456789abcdef
0000000000000108 0000000000000010
@60
0 1 5
4 2 fffffffffffffffd
8 3 2
c 4 fffffffffffffffd
10 5 0
14 6 7
18 7 5
20 8 100
24 9 0123456789abcdef
28 a 0123456789abcdf4
30 b 10
38 c 1
48 f 11
50 10 5
@c0
110 0123456789abcdf4
118 11
